//--- design/best_match_select.sv
`timescale 1ns/10ps
`default_nettype none

module best_match_select (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    sad_valid,
    input  wire me_pkg::sad_t      sad_value,
    input  wire me_pkg::cand_idx_t sad_idx,
    input  wire                    sad_last,
    output logic                   res_push,
    output me_pkg::result_t        res_data
);

    import me_pkg::*;

    sad_t      min_sad;
    cand_idx_t min_idx;
    logic      take;
    sad_t      next_sad;
    cand_idx_t next_idx;

    // candidate 0 always loads, a later one needs a strictly lower sad
    assign take     = (sad_idx == '0) || (sad_value < min_sad);
    assign next_sad = take ? sad_value : min_sad;
    assign next_idx = take ? sad_idx : min_idx;

    always_ff @(posedge clk) begin
        if (rst)
            res_push <= 1'b0;
        else
            res_push <= sad_valid && sad_last;
    end

    always_ff @(posedge clk) begin
        if (sad_valid) begin
            if (sad_last) begin
                res_data.best_idx <= next_idx;
                res_data.best_sad <= next_sad;
                min_sad           <= '1;
                min_idx           <= '0;
            end else begin
                min_sad <= next_sad;
                min_idx <= next_idx;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cand_issue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cand_issue_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    fifo_empty,
    input  wire me_pkg::block_t    fifo_data,
    input  wire                    need_cur,
    input  wire                    slot_free,
    output logic                   cand_pop,
    output logic                   next_block,
    output logic                   issue_valid,
    output me_pkg::block_t         issue_block,
    output me_pkg::cand_idx_t      issue_idx,
    output logic                   issue_last
);

    import me_pkg::*;

    logic                                   primed;
    logic                                   prime_pulse;
    logic                                   in_block;
    cand_idx_t                              idx_cnt;
    logic [$clog2(RESULT_FIFO_DEPTH+1)-1:0] reserved;
    logic                                   start;

    // a new block needs its pixels loaded and a free result slot
    assign start = primed && !prime_pulse && !in_block && !need_cur && !fifo_empty
                   && (reserved < RESULT_FIFO_DEPTH);

    assign cand_pop   = start || (in_block && !fifo_empty);
    assign next_block = prime_pulse || start;

    // first pulse after reset only fills the idle half
    always_ff @(posedge clk) begin
        if (rst) begin
            primed      <= 1'b0;
            prime_pulse <= 1'b0;
        end else begin
            primed      <= 1'b1;
            prime_pulse <= !primed;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_block    <= 1'b0;
            idx_cnt     <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= cand_pop;
            if (cand_pop) begin
                idx_cnt  <= idx_cnt + 1'b1;
                in_block <= (idx_cnt != CAND_IDX_W'(N_CAND - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reserved <= '0;
        end else begin
            case ({start, slot_free})
                2'b10:   reserved <= reserved + 1'b1;
                2'b01:   reserved <= reserved - 1'b1;
                default: reserved <= reserved;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cand_pop) begin
            issue_block <= fifo_data;
            issue_idx   <= idx_cnt;
            issue_last  <= (idx_cnt == CAND_IDX_W'(N_CAND - 1));
        end
    end

endmodule

`default_nettype wire

//--- design/credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      pop_data,
    output logic          empty,
    output logic          credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            // each freed entry hands one credit back upstream
            credit <= pop;
        end
    end

    assign pop_data = mem[rd_ptr];
    assign empty    = (count == '0);

endmodule

`default_nettype wire

//--- design/cur_block_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module cur_block_buffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          next_block,
    input  wire [me_pkg::CUR_WORD_W-1:0] cur_in,
    output logic                         need_cur,
    output me_pkg::block_t               cur_rows
);

    import me_pkg::*;

    // half selects the block being read, the other one is loaded
    block_t                       buf_0;
    block_t                       buf_1;
    logic                         half;
    logic [$clog2(CUR_WORDS)-1:0] addr;
    logic                         at_inter;
    logic [$clog2(BLK_DIM)-1:0]   inter_state;

    always_ff @(posedge clk) begin
        if (need_cur) begin
            if (half)
                buf_0[addr*CUR_WORD_W +: CUR_WORD_W] <= cur_in;
            else
                buf_1[addr*CUR_WORD_W +: CUR_WORD_W] <= cur_in;
        end
    end

    // 16 load words per block, one per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            need_cur <= 1'b0;
            addr     <= '0;
        end else if (next_block) begin
            need_cur <= 1'b1;
            addr     <= '0;
        end else if (need_cur) begin
            addr <= addr + 1'b1;
            if (addr == CUR_WORDS - 1)
                need_cur <= 1'b0;
        end
    end

    // switch-over walks down one row per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            half        <= 1'b0;
            at_inter    <= 1'b0;
            inter_state <= '0;
        end else if (next_block) begin
            half        <= ~half;
            at_inter    <= 1'b1;
            inter_state <= '0;
        end else if (at_inter) begin
            if (inter_state == BLK_DIM - 2) begin
                at_inter    <= 1'b0;
                inter_state <= '0;
            end else begin
                inter_state <= inter_state + 1'b1;
            end
        end
    end

    always_comb begin
        logic take_new;
        logic sel;
        for (int r = 0; r < BLK_DIM; r++) begin
            // row r moves to the new half r cycles after the flip
            take_new = !at_inter || (inter_state >= r);
            sel      = take_new ? half : ~half;
            if (sel)
                cur_rows[r*ROW_W +: ROW_W] = buf_1[r*ROW_W +: ROW_W];
            else
                cur_rows[r*ROW_W +: ROW_W] = buf_0[r*ROW_W +: ROW_W];
        end
    end

endmodule

`default_nettype wire

//--- design/me_pkg.sv
`default_nettype none

package me_pkg;

    localparam int PIX_W   = 8;
    localparam int BLK_DIM = 8;
    localparam int ROW_W   = PIX_W * BLK_DIM;
    localparam int BLK_W   = ROW_W * BLK_DIM;

    // current block arrives four pixels per word
    localparam int CUR_WORD_W = 32;
    localparam int CUR_WORDS  = BLK_W / CUR_WORD_W;

    localparam int N_CAND     = 16;
    // worst case sad is 64 * 255 = 16320
    localparam int SAD_W      = 14;
    localparam int CAND_IDX_W = 4;

    localparam int CAND_FIFO_DEPTH   = 4;
    localparam int RESULT_FIFO_DEPTH = 2;
    localparam int RESULT_CREDITS    = 2;

    typedef logic [PIX_W-1:0]      pixel_t;
    // pixel 0 in the low byte
    typedef logic [ROW_W-1:0]      row_t;
    // row 0 in the low 64 bits
    typedef logic [BLK_W-1:0]      block_t;
    typedef logic [SAD_W-1:0]      sad_t;
    typedef logic [CAND_IDX_W-1:0] cand_idx_t;

    typedef struct packed {
        cand_idx_t best_idx;
        sad_t      best_sad;
    } result_t;

endpackage

`default_nettype wire

//--- design/me_sad_top.sv
`timescale 1ns/10ps
`default_nettype none

module me_sad_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cand_valid,
    input  wire me_pkg::block_t          cand_block,
    output logic                         cand_credit,
    input  wire [me_pkg::CUR_WORD_W-1:0] cur_in,
    output logic                         need_cur,
    input  wire                          result_credit,
    output logic                         result_valid,
    output me_pkg::cand_idx_t            best_idx,
    output me_pkg::sad_t                 best_sad
);

    import me_pkg::*;

    logic      cand_empty;
    block_t    cand_head;
    logic      cand_pop;
    logic      next_block;
    logic      issue_valid;
    block_t    issue_block;
    cand_idx_t issue_idx;
    logic      issue_last;
    block_t    cur_rows;
    logic      sad_valid;
    sad_t      sad_value;
    cand_idx_t sad_idx;
    logic      sad_last;
    logic      res_push;
    result_t   res_data;
    logic      slot_free;

    credit_fifo #(
        .payload_t (block_t),
        .DEPTH     (CAND_FIFO_DEPTH)
    ) cand_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (cand_valid),
        .push_data (cand_block),
        .pop       (cand_pop),
        .pop_data  (cand_head),
        .empty     (cand_empty),
        .credit    (cand_credit)
    );

    cand_issue_ctrl issue_ctrl (
        .clk         (clk),
        .rst         (rst),
        .fifo_empty  (cand_empty),
        .fifo_data   (cand_head),
        .need_cur    (need_cur),
        .slot_free   (slot_free),
        .cand_pop    (cand_pop),
        .next_block  (next_block),
        .issue_valid (issue_valid),
        .issue_block (issue_block),
        .issue_idx   (issue_idx),
        .issue_last  (issue_last)
    );

    cur_block_buffer cur_buf (
        .clk        (clk),
        .rst        (rst),
        .next_block (next_block),
        .cur_in     (cur_in),
        .need_cur   (need_cur),
        .cur_rows   (cur_rows)
    );

    sad_row_pipeline sad_pipe (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_block (issue_block),
        .issue_idx   (issue_idx),
        .issue_last  (issue_last),
        .cur_rows    (cur_rows),
        .sad_valid   (sad_valid),
        .sad_value   (sad_value),
        .sad_idx     (sad_idx),
        .sad_last    (sad_last)
    );

    best_match_select best_sel (
        .clk       (clk),
        .rst       (rst),
        .sad_valid (sad_valid),
        .sad_value (sad_value),
        .sad_idx   (sad_idx),
        .sad_last  (sad_last),
        .res_push  (res_push),
        .res_data  (res_data)
    );

    result_egress egress (
        .clk           (clk),
        .rst           (rst),
        .res_push      (res_push),
        .res_data      (res_data),
        .result_credit (result_credit),
        .result_valid  (result_valid),
        .best_idx      (best_idx),
        .best_sad      (best_sad),
        .slot_free     (slot_free)
    );

endmodule

`default_nettype wire

//--- design/result_egress.sv
`timescale 1ns/10ps
`default_nettype none

module result_egress (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  res_push,
    input  wire me_pkg::result_t res_data,
    input  wire                  result_credit,
    output logic                 result_valid,
    output me_pkg::cand_idx_t    best_idx,
    output me_pkg::sad_t         best_sad,
    output logic                 slot_free
);

    import me_pkg::*;

    result_t                             head;
    logic                                empty;
    logic                                pop;
    logic [$clog2(RESULT_CREDITS+1)-1:0] credits;

    credit_fifo #(
        .payload_t (result_t),
        .DEPTH     (RESULT_FIFO_DEPTH)
    ) res_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (res_push),
        .push_data (res_data),
        .pop       (pop),
        .pop_data  (head),
        .empty     (empty),
        .credit    (slot_free)
    );

    // send only while the consumer has room
    assign pop = !empty && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits      <= $bits(credits)'(RESULT_CREDITS);
            result_valid <= 1'b0;
        end else begin
            result_valid <= pop;
            case ({pop, result_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            best_idx <= head.best_idx;
            best_sad <= head.best_sad;
        end
    end

endmodule

`default_nettype wire

//--- design/sad_row_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module sad_row_pipeline (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    issue_valid,
    input  wire me_pkg::block_t    issue_block,
    input  wire me_pkg::cand_idx_t issue_idx,
    input  wire                    issue_last,
    input  wire me_pkg::block_t    cur_rows,
    output logic                   sad_valid,
    output me_pkg::sad_t           sad_value,
    output me_pkg::cand_idx_t      sad_idx,
    output logic                   sad_last
);

    import me_pkg::*;

    // slot s holds a candidate about to add row s
    logic      st_valid [BLK_DIM+1];
    sad_t      st_sum   [BLK_DIM+1];
    cand_idx_t st_idx   [BLK_DIM+1];
    logic      st_last  [BLK_DIM+1];
    // rows not yet summed, next one in the low bits
    block_t    st_rows  [BLK_DIM];

    function automatic logic [PIX_W+2:0] row_sad(row_t cand, row_t cur);
        logic [PIX_W+2:0] acc;
        pixel_t           a;
        pixel_t           b;
        acc = '0;
        for (int i = 0; i < BLK_DIM; i++) begin
            a   = cand[i*PIX_W +: PIX_W];
            b   = cur[i*PIX_W +: PIX_W];
            acc = acc + ((a > b) ? a - b : b - a);
        end
        return acc;
    endfunction

    assign st_valid[0] = issue_valid;
    assign st_sum[0]   = '0;
    assign st_idx[0]   = issue_idx;
    assign st_last[0]  = issue_last;
    assign st_rows[0]  = issue_block;

    for (genvar s = 0; s < BLK_DIM; s++) begin : g_stage
        always_ff @(posedge clk) begin
            if (rst)
                st_valid[s+1] <= 1'b0;
            else
                st_valid[s+1] <= st_valid[s];
        end

        always_ff @(posedge clk) begin
            st_sum[s+1]  <= st_sum[s] + SAD_W'(row_sad(st_rows[s][ROW_W-1:0],
                                                       cur_rows[s*ROW_W +: ROW_W]));
            st_idx[s+1]  <= st_idx[s];
            st_last[s+1] <= st_last[s];
        end

        if (s < BLK_DIM - 1) begin : g_shift
            always_ff @(posedge clk) begin
                st_rows[s+1] <= st_rows[s] >> ROW_W;
            end
        end
    end

    assign sad_valid = st_valid[BLK_DIM];
    assign sad_value = st_sum[BLK_DIM];
    assign sad_idx   = st_idx[BLK_DIM];
    assign sad_last  = st_last[BLK_DIM];

endmodule

`default_nettype wire

//--- me_sad.f
design/me_pkg.sv
design/credit_fifo.sv
design/cand_issue_ctrl.sv
design/cur_block_buffer.sv
design/sad_row_pipeline.sv
design/best_match_select.sv
design/result_egress.sv
design/me_sad_top.sv
testbench/me_sad_asserts.sv
testbench/me_sad_tb.sv

//--- testbench/me_sad_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module me_sad_asserts (
    input wire clk,
    input wire rst,
    input wire cand_valid,
    input wire cand_pop,
    input wire next_block,
    input wire need_cur,
    input wire result_valid,
    input wire result_credit
);

    import me_pkg::*;

    // shadow counts of candidate fifo occupancy and consumer credits
    int cand_occ;
    int res_credits;
    // failed assertions so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            cand_occ    <= 0;
            res_credits <= RESULT_CREDITS;
        end else begin
            cand_occ    <= cand_occ + int'(cand_valid) - int'(cand_pop);
            res_credits <= res_credits - int'(result_valid) + int'(result_credit);
        end
    end

    load_window: assert property (@(posedge clk) disable iff (rst)
        next_block |=> need_cur [*CUR_WORDS] ##1 !need_cur)
        else begin
            $error("need_cur window after next_block is not %0d cycles", CUR_WORDS);
            fail_count++;
        end

    no_full_push: assert property (@(posedge clk) disable iff (rst)
        cand_valid |-> (cand_occ < CAND_FIFO_DEPTH) || cand_pop)
        else begin
            $error("candidate pushed into a full fifo");
            fail_count++;
        end

    result_has_credit: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> res_credits > 0)
        else begin
            $error("result_valid with no consumer credit left");
            fail_count++;
        end

endmodule

bind me_sad_top me_sad_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .cand_valid    (cand_valid),
    .cand_pop      (cand_pop),
    .next_block    (next_block),
    .need_cur      (need_cur),
    .result_valid  (result_valid),
    .result_credit (result_credit)
);

`default_nettype wire

//--- testbench/me_sad_tb.sv
`timescale 1ns/10ps
`default_nettype none

module me_sad_tb;

    import me_pkg::*;

    localparam int TOTAL_BLOCKS = 19;
    localparam int CYCLE_LIMIT  = TOTAL_BLOCKS * N_CAND * 4 + 200;
    localparam int HOLD_CYCLES  = 120;

    logic                  clk;
    logic                  rst;
    logic                  cand_valid;
    block_t                cand_block;
    logic                  cand_credit;
    logic [CUR_WORD_W-1:0] cur_in;
    logic                  need_cur;
    logic                  result_credit;
    logic                  result_valid;
    cand_idx_t             best_idx;
    sad_t                  best_sad;

    integer seed   = 98059;
    int     cycles = 0;
    int     errors;
    int     checks;
    int     tests;
    int     asserts_seen;

    block_t                cand_q [$];
    logic [CUR_WORD_W-1:0] word_q [$];
    result_t               exp_q  [$];
    block_t                cand_set [N_CAND];

    // sender and consumer bookkeeping, cleared on every reset
    int snd_credits;
    int sent;
    int credits_back;
    int pending_res;
    int credits_given;
    int results_seen;

    me_sad_top u_me_sad_top (
        .clk           (clk),
        .rst           (rst),
        .cand_valid    (cand_valid),
        .cand_block    (cand_block),
        .cand_credit   (cand_credit),
        .cur_in        (cur_in),
        .need_cur      (need_cur),
        .result_credit (result_credit),
        .result_valid  (result_valid),
        .best_idx      (best_idx),
        .best_sad      (best_sad)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: results still missing after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic int rand_pct();
        return {$random(seed)} % 100;
    endfunction

    function automatic block_t rand_block();
        block_t b;
        for (int w = 0; w < BLK_W / 32; w++)
            b[w*32 +: 32] = $random(seed);
        return b;
    endfunction

    function automatic int block_sad(block_t cand, block_t cur);
        int sum;
        int a;
        int b;
        sum = 0;
        for (int p = 0; p < BLK_DIM * BLK_DIM; p++) begin
            a   = int'(cand[p*PIX_W +: PIX_W]);
            b   = int'(cur[p*PIX_W +: PIX_W]);
            sum = sum + ((a > b) ? a - b : b - a);
        end
        return sum;
    endfunction

    task automatic check_result(input cand_idx_t got_idx, input sad_t got_sad,
                                input result_t exp);
        checks++;
        if (got_idx !== exp.best_idx) begin
            $display("MISMATCH at %0t: best_idx got %0d expected %0d",
                     $time, got_idx, exp.best_idx);
            errors++;
        end
        if (got_sad !== exp.best_sad) begin
            $display("MISMATCH at %0t: best_sad got %0d expected %0d",
                     $time, got_sad, exp.best_sad);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < N_CAND; i++)
            cand_set[i] = rand_block();
    endtask

    // queue one block: its load words, its candidates and the model's result
    task automatic add_block(input block_t cur);
        result_t exp;
        int      s;
        int      best;
        exp.best_idx = '0;
        best         = block_sad(cand_set[0], cur);
        for (int i = 0; i < N_CAND; i++) begin
            cand_q.push_back(cand_set[i]);
            s = block_sad(cand_set[i], cur);
            // equal sad keeps the earlier index
            if (s < best) begin
                best         = s;
                exp.best_idx = cand_idx_t'(i);
            end
        end
        exp.best_sad = sad_t'(best);
        exp_q.push_back(exp);
        for (int w = 0; w < CUR_WORDS; w++)
            word_q.push_back(cur[w*CUR_WORD_W +: CUR_WORD_W]);
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst           = 1'b1;
        cand_valid    = 1'b0;
        cand_block    = '0;
        cur_in        = '0;
        result_credit = 1'b0;
        cand_q.delete();
        word_q.delete();
        exp_q.delete();
        snd_credits   = CAND_FIFO_DEPTH;
        sent          = 0;
        credits_back  = 0;
        pending_res   = 0;
        credits_given = RESULT_CREDITS;
        results_seen  = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic collect_outputs();
        result_t exp;
        if (cand_credit) begin
            snd_credits++;
            credits_back++;
            if (credits_back > sent) begin
                $display("ERROR at %0t: cand_credit pulse with no candidate outstanding",
                         $time);
                errors++;
            end
        end
        if (result_valid) begin
            results_seen++;
            pending_res++;
            if (results_seen > credits_given) begin
                $display("ERROR at %0t: result sent beyond the consumer credits", $time);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: result arrived with no block outstanding", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                check_result(best_idx, best_sad, exp);
            end
        end
    endtask

    task automatic drive_inputs(input int gap_pct, input bit hold);
        if (need_cur && word_q.size() > 0)
            cur_in = word_q.pop_front();
        else
            cur_in = '0;
        cand_valid = 1'b0;
        if (cand_q.size() > 0 && snd_credits > 0 && rand_pct() >= gap_pct) begin
            cand_valid = 1'b1;
            cand_block = cand_q.pop_front();
            snd_credits--;
            sent++;
        end
        result_credit = 1'b0;
        if (!hold && pending_res > 0 && rand_pct() < 60) begin
            result_credit = 1'b1;
            pending_res--;
            credits_given++;
        end
    endtask

    task automatic run_test(input string name, input int gap_pct, input int hold);
        int n;
        int err0;
        int blocks;
        n      = 0;
        err0   = errors;
        blocks = exp_q.size();
        while (exp_q.size() > 0) begin
            @(negedge clk);
            collect_outputs();
            if (hold > 0 && n == hold)
                check_count("results while credits withheld", results_seen, RESULT_CREDITS);
            drive_inputs(gap_pct, n < hold);
            n++;
        end
        // a few idle cycles catch stray results and late credits
        repeat (12) begin
            @(negedge clk);
            collect_outputs();
            drive_inputs(gap_pct, 1'b0);
        end
        check_count("cand_credit pulses", credits_back, sent);
        check_count("results", results_seen, blocks);
        // bound checker failures since the last test
        errors       = errors + u_me_sad_top.u_asserts.fail_count - asserts_seen;
        asserts_seen = u_me_sad_top.u_asserts.fail_count;
        tests++;
        $display("test %0d %s: %0d blocks, %0d errors", tests, name, blocks, errors - err0);
    endtask

    initial begin
        block_t cur;
        block_t near;
        rst           = 1'b1;
        cand_valid    = 1'b0;
        cand_block    = '0;
        cur_in        = '0;
        result_credit = 1'b0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        asserts_seen  = 0;

        reset_dut();
        cur = rand_block();
        fill_random();
        cand_set[9] = cur;
        add_block(cur);
        run_test("exact match", 0, 0);

        reset_dut();
        for (int b = 0; b < 6; b++) begin
            fill_random();
            add_block(rand_block());
        end
        run_test("back to back", 0, 0);

        reset_dut();
        for (int b = 0; b < 4; b++) begin
            fill_random();
            add_block(rand_block());
        end
        run_test("input gaps", 40, 0);

        // three copies one step from the current block, then all equal
        reset_dut();
        cur = rand_block();
        fill_random();
        near        = cur;
        near[7:0]   = cur[7:0] ^ 8'h01;
        cand_set[3]  = near;
        cand_set[11] = near;
        cand_set[14] = near;
        add_block(cur);
        near = rand_block();
        for (int i = 0; i < N_CAND; i++)
            cand_set[i] = near;
        add_block(rand_block());
        run_test("ties", 20, 0);

        reset_dut();
        for (int b = 0; b < 6; b++) begin
            fill_random();
            add_block(rand_block());
        end
        run_test("result back-pressure", 0, HOLD_CYCLES);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
